//--- design/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    localparam int word_w     = 32;
    localparam int line_words = 4;
    localparam int num_ways   = 2;
    localparam int num_sets   = 64;
    localparam int offset_w   = 4;
    localparam int index_w    = 6;
    localparam int tag_w      = 22;

    typedef logic [31:0]                      addr_t;
    typedef logic [word_w-1:0]                word_t;
    typedef logic [tag_w-1:0]                 tag_t;
    typedef logic [index_w-1:0]               index_t;
    typedef logic [offset_w-1:0]              offset_t;
    typedef logic [word_w/8-1:0]              wstrb_t;
    typedef logic [$clog2(num_ways)-1:0]      way_t;
    typedef logic [num_ways-1:0]              hit_t; // one-hot
    typedef logic [line_words*word_w-1:0]     line_t; // word 0 in the low bits

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } load_size_e;

    typedef enum logic [2:0] {
        st_lookup,
        st_store,
        st_miss_dirty,
        st_writeback,
        st_miss_clean,
        st_refill,
        st_refill_done
    } dc_state_e;

    // wdata of a cpu request is lane aligned
    typedef struct packed {
        logic       write;
        addr_t      addr;
        wstrb_t     wstrb;
        word_t      wdata;
        load_size_e size;
        logic       sign;
    } cpu_req_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;  // line aligned
        line_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  rd_rdy;
        logic  ret_valid;
        line_t ret_data;
        logic  wr_rdy;
        logic  wr_valid;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- design/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     held_valid,
    input  logic     held_write,
    input  hit_t     hit,
    input  logic     victim_dirty,
    input  mem_rsp_t mem_rsp,
    output logic     busy,
    output logic     resp_valid,
    output logic     mem_rd,
    output logic     mem_wr,
    output logic     refill_we,
    output logic     store_we,
    output logic     lru_update
);

    dc_state_e state;
    dc_state_e state_next;
    logic      any_hit;
    logic      lookup_req;

    assign any_hit    = |hit;
    assign lookup_req = (state == st_lookup) && held_valid; // held request judged now

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_lookup;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_lookup: begin
                if (held_valid) begin
                    if (!any_hit) begin
                        // dirty victim goes out before the refill
                        state_next = victim_dirty ? st_miss_dirty : st_miss_clean;
                    end else if (held_write) begin
                        state_next = st_store;
                    end
                end
            end
            st_store: begin
                state_next = st_lookup;
            end
            st_miss_dirty: begin
                if (mem_rsp.wr_rdy) begin
                    state_next = st_writeback;
                end
            end
            st_writeback: begin
                if (mem_rsp.wr_valid) begin
                    state_next = st_miss_clean;
                end
            end
            st_miss_clean: begin
                if (mem_rsp.rd_rdy) begin
                    state_next = st_refill;
                end
            end
            st_refill: begin
                if (mem_rsp.ret_valid) begin
                    state_next = st_refill_done;
                end
            end
            st_refill_done: begin
                state_next = st_lookup; // arrays re-read the refilled set
            end
            default: begin
                state_next = st_lookup;
            end
        endcase
    end

    always_comb begin
        busy       = 1'b1;
        resp_valid = 1'b0;
        case (state)
            st_lookup: begin
                busy       = held_valid && (!any_hit || held_write);
                resp_valid = lookup_req && any_hit && !held_write;
            end
            st_store: begin
                // merged line written at the end of this cycle
                busy       = 1'b0;
                resp_valid = 1'b1;
            end
            default: begin
                busy       = 1'b1;
                resp_valid = 1'b0;
            end
        endcase
    end

    // level requests stay up until the memory takes them
    assign mem_wr = (state == st_miss_dirty);
    assign mem_rd = (state == st_miss_clean);

    assign refill_we  = (state == st_refill) && mem_rsp.ret_valid;
    assign store_we   = (state == st_store);
    assign lru_update = (lookup_req && any_hit) || refill_we;

endmodule

`default_nettype wire

//--- design/dcache_ways.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ways import dcache_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  index_t rd_index,
    input  index_t held_index,
    input  tag_t   held_tag,
    input  logic   refill_we,
    input  logic   store_we,
    input  way_t   victim,
    input  line_t  refill_line,
    input  line_t  store_line,
    output hit_t   hit,
    output line_t  hit_line,
    output line_t  victim_line,
    output tag_t   victim_tag,
    output logic   victim_dirty
);

    hit_t  way_we;
    line_t wr_line;
    logic  same_set;

    tag_t  tag_q   [num_ways];
    line_t data_q  [num_ways];
    logic  valid_q [num_ways];
    logic  dirty_q [num_ways];

    assign wr_line  = refill_we ? refill_line : store_line;
    assign same_set = (rd_index == held_index); // read meets this edge's write

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        tag_t                tag_mem  [num_sets];
        line_t               data_mem [num_sets];
        logic [num_sets-1:0] valid_bits;
        logic [num_sets-1:0] dirty_bits;

        // refill goes to the victim, a store to the way it hit
        assign way_we[w] = (refill_we && (victim == w)) || (store_we && hit[w]);

        always_ff @(posedge clk) begin
            if (way_we[w]) begin
                tag_mem[held_index]  <= held_tag; // unchanged on a store
                data_mem[held_index] <= wr_line;
            end
            if (way_we[w] && same_set) begin
                tag_q[w]  <= held_tag;
                data_q[w] <= wr_line;
            end else begin
                tag_q[w]  <= tag_mem[rd_index];
                data_q[w] <= data_mem[rd_index];
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid_bits <= '0;
                dirty_bits <= '0;
                valid_q[w] <= 1'b0;
                dirty_q[w] <= 1'b0;
            end else begin
                if (way_we[w]) begin
                    valid_bits[held_index] <= 1'b1;
                    dirty_bits[held_index] <= store_we; // refill leaves it clean
                end
                if (way_we[w] && same_set) begin
                    valid_q[w] <= 1'b1;
                    dirty_q[w] <= store_we;
                end else begin
                    valid_q[w] <= valid_bits[rd_index];
                    dirty_q[w] <= dirty_bits[rd_index];
                end
            end
        end

        assign hit[w] = valid_q[w] && (tag_q[w] == held_tag);
    end

    assign hit_line     = hit[1] ? data_q[1] : data_q[0];
    assign victim_line  = data_q[victim];
    assign victim_tag   = tag_q[victim];
    assign victim_dirty = valid_q[victim] && dirty_q[victim];

endmodule

`default_nettype wire

//--- design/dcache_plru.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_plru import dcache_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  index_t index,
    input  logic   update,
    input  hit_t   hit,
    input  way_t   refill_way,
    output way_t   victim
);

    logic [num_sets-1:0] lru_bits; // names the older way of each set
    way_t                used_way;

    // no hit while refilling, so the refill way is taken then
    assign used_way = (|hit) ? way_t'(hit[1]) : refill_way;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lru_bits <= '0;
        end else if (update) begin
            lru_bits[index] <= ~used_way;
        end
    end

    assign victim = lru_bits[index];

endmodule

`default_nettype wire

//--- design/dcache_word_path.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_word_path import dcache_pkg::*; (
    input  line_t      hit_line,
    input  offset_t    offset,
    input  wstrb_t     wstrb,
    input  word_t      wdata,
    input  load_size_e size,
    input  logic       sign,
    output word_t      load_data,
    output line_t      store_line
);

    logic [1:0] word_sel;
    word_t      word;
    logic [7:0] byte_val;
    logic [15:0] half_val;

    assign word_sel = offset[offset_w-1:2];
    assign word     = hit_line[word_sel*word_w +: word_w];
    assign byte_val = word[offset[1:0]*8 +: 8];
    assign half_val = word[offset[1]*16 +: 16]; // halfword lane from bit 1

    always_comb begin
        case (size)
            size_byte: begin
                load_data = {{(word_w-8){sign & byte_val[7]}}, byte_val};
            end
            size_half: begin
                load_data = {{(word_w-16){sign & half_val[15]}}, half_val};
            end
            default: begin
                load_data = word;
            end
        endcase
    end

    // strobed bytes replace the addressed word
    always_comb begin
        word_t merged;
        merged = word;
        for (int b = 0; b < word_w/8; b++) begin
            if (wstrb[b]) begin
                merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        store_line = hit_line;
        store_line[word_sel*word_w +: word_w] = merged;
    end

endmodule

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     req_valid,
    input  cpu_req_t req,
    input  mem_rsp_t mem_rsp,
    output logic     busy,
    output logic     resp_valid,
    output word_t    rdata,
    output mem_req_t mem_req
);

    cpu_req_t req_q;
    logic     held_valid;
    tag_t     held_tag;
    index_t   held_index;
    offset_t  held_offset;
    index_t   rd_index;
    hit_t     hit;
    way_t     victim;
    line_t    hit_line;
    line_t    victim_line;
    line_t    store_line;
    tag_t     victim_tag;
    logic     victim_dirty;
    logic     mem_rd;
    logic     mem_wr;
    logic     refill_we;
    logic     store_we;
    logic     lru_update;

    // request register only moves while the cache is free
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held_valid <= 1'b0;
        end else if (!busy) begin
            held_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            req_q <= req;
        end
    end

    assign held_offset = req_q.addr[offset_w-1:0];
    assign held_index  = req_q.addr[offset_w +: index_w];
    assign held_tag    = req_q.addr[offset_w+index_w +: tag_w];

    // look ahead at the incoming set unless stalled
    assign rd_index = busy ? held_index : req.addr[offset_w +: index_w];

    assign mem_req.rd    = mem_rd;
    assign mem_req.wr    = mem_wr;
    assign mem_req.addr  = mem_wr ? {victim_tag, held_index, {offset_w{1'b0}}}
                                  : {held_tag, held_index, {offset_w{1'b0}}};
    assign mem_req.wdata = victim_line;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .held_valid   (held_valid),
        .held_write   (req_q.write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_rsp      (mem_rsp),
        .busy         (busy),
        .resp_valid   (resp_valid),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr),
        .refill_we    (refill_we),
        .store_we     (store_we),
        .lru_update   (lru_update)
    );

    dcache_ways u_ways (
        .clk          (clk),
        .arst_n       (arst_n),
        .rd_index     (rd_index),
        .held_index   (held_index),
        .held_tag     (held_tag),
        .refill_we    (refill_we),
        .store_we     (store_we),
        .victim       (victim),
        .refill_line  (mem_rsp.ret_data),
        .store_line   (store_line),
        .hit          (hit),
        .hit_line     (hit_line),
        .victim_line  (victim_line),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    dcache_plru u_plru (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (held_index),
        .update     (lru_update),
        .hit        (hit),
        .refill_way (victim),
        .victim     (victim)
    );

    dcache_word_path u_word_path (
        .hit_line   (hit_line),
        .offset     (held_offset),
        .wstrb      (req_q.wstrb),
        .wdata      (req_q.wdata),
        .size       (req_q.size),
        .sign       (req_q.sign),
        .load_data  (rdata),
        .store_line (store_line)
    );

endmodule

`default_nettype wire

//--- verif/dcache_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_mem_model import dcache_pkg::*; #(
    parameter logic [31:0] seed = 32'h3741_8583
) (
    input  logic     clk,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp
);

    localparam int mem_lines = 256; // 4 KiB backing store

    line_t       mem [mem_lines];
    logic [31:0] rng;
    addr_t       req_addr;
    line_t       req_data;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int draw_delay(input int span);
        rng = xorshift32(rng);
        return int'(rng % span);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        rng     = seed;
        mem_rsp = '0;
        for (int l = 0; l < mem_lines; l++) begin
            for (int b = 0; b < 16; b++) begin
                mem[l][b*8 +: 8] = 8'((l*16 + b)*7 + 3);
            end
        end
        forever begin
            @(posedge clk);
            #2;
            if (mem_req.wr === 1'b1) begin
                idle_cycles(draw_delay(4));
                req_addr       = mem_req.addr;
                req_data       = mem_req.wdata;
                mem_rsp.wr_rdy = 1'b1; // cache lets go of wr at the next edge
                idle_cycles(1);
                mem_rsp.wr_rdy = 1'b0;
                idle_cycles(draw_delay(5));
                mem[req_addr[11:4]] = req_data;
                mem_rsp.wr_valid    = 1'b1;
                idle_cycles(1);
                mem_rsp.wr_valid = 1'b0;
            end else if (mem_req.rd === 1'b1) begin
                idle_cycles(draw_delay(4));
                req_addr       = mem_req.addr;
                mem_rsp.rd_rdy = 1'b1;
                idle_cycles(1);
                mem_rsp.rd_rdy = 1'b0;
                idle_cycles(draw_delay(5));
                mem_rsp.ret_data  = mem[req_addr[11:4]];
                mem_rsp.ret_valid = 1'b1;
                idle_cycles(1);
                mem_rsp.ret_valid = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

    localparam int num_random = 400;
    localparam int ref_bytes  = 4096;
    localparam int resp_limit = 150; // cycles allowed per request

    typedef struct packed {
        logic       write;
        addr_t      addr;
        wstrb_t     wstrb;
        word_t      wdata;
        load_size_e size;
        logic       sign;
        word_t      exp_data;
        logic [1:0] exp_rd; // memory reads expected during the row
        logic [1:0] exp_wr;
    } row_t;

    logic     clk;
    logic     arst_n;
    logic     req_valid;
    cpu_req_t req;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     busy;
    logic     resp_valid;
    word_t    rdata;

    logic [7:0]  ref_mem [ref_bytes];
    row_t        rows [$];
    logic [31:0] rng;
    addr_t       cur_addr;
    int          mismatch_count;
    int          other_count;
    int          req_count;
    int          pulse_count;
    int          rd_count;
    int          wr_count;
    logic        rd_q;
    logic        wr_q;

    dcache_top uut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .mem_rsp    (mem_rsp),
        .busy       (busy),
        .resp_valid (resp_valid),
        .rdata      (rdata),
        .mem_req    (mem_req)
    );

    dcache_mem_model #(.seed(32'h3741_8583)) u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t ref_load(input addr_t addr, input load_size_e size,
                                       input logic sign);
        word_t       w;
        logic [7:0]  by;
        logic [15:0] hw;
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = ref_mem[{addr[11:2], 2'(b)}];
        end
        by = ref_mem[addr[11:0]];
        hw = addr[1] ? w[31:16] : w[15:0];
        case (size)
            size_byte: ref_load = {{24{sign & by[7]}}, by};
            size_half: ref_load = {{16{sign & hw[15]}}, hw};
            default:   ref_load = w;
        endcase
    endfunction

    function automatic line_t ref_line(input addr_t addr);
        line_t l;
        for (int b = 0; b < 16; b++) begin
            l[b*8 +: 8] = ref_mem[{addr[11:4], 4'(b)}];
        end
        return l;
    endfunction

    task automatic ref_store(input addr_t addr, input wstrb_t wstrb, input word_t wdata);
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                ref_mem[{addr[11:2], 2'(b)}] = wdata[b*8 +: 8];
            end
        end
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
            mismatch_count++;
        end
    endtask

    task automatic add_row(input logic write, input addr_t addr, input wstrb_t wstrb,
                           input word_t wdata, input load_size_e size, input logic sign,
                           input word_t exp_data, input int exp_rd, input int exp_wr);
        row_t r;
        r.write    = write;
        r.addr     = addr;
        r.wstrb    = wstrb;
        r.wdata    = wdata;
        r.size     = size;
        r.sign     = sign;
        r.exp_data = exp_data;
        r.exp_rd   = 2'(exp_rd);
        r.exp_wr   = 2'(exp_wr);
        rows.push_back(r);
    endtask

    task automatic build_table();
        // cold miss in set 1 then hits of every size
        add_row(1'b0, 32'h0000_0014, 4'h0, 32'h0, size_word, 1'b0, 32'ha49d_968f, 1, 0);
        add_row(1'b0, 32'h0000_0018, 4'h0, 32'h0, size_word, 1'b0, 32'hc0b9_b2ab, 0, 0);
        add_row(1'b0, 32'h0000_0015, 4'h0, 32'h0, size_byte, 1'b1, 32'hffff_ff96, 0, 0);
        add_row(1'b0, 32'h0000_0015, 4'h0, 32'h0, size_byte, 1'b0, 32'h0000_0096, 0, 0);
        add_row(1'b0, 32'h0000_0016, 4'h0, 32'h0, size_half, 1'b1, 32'hffff_a49d, 0, 0);
        add_row(1'b0, 32'h0000_0014, 4'h0, 32'h0, size_half, 1'b0, 32'h0000_968f, 0, 0);
        // byte and halfword stores into the same line
        add_row(1'b1, 32'h0000_0011, 4'h2, 32'h0000_5a00, size_word, 1'b0, 32'h0, 0, 0);
        add_row(1'b1, 32'h0000_0012, 4'hc, 32'hc3f1_0000, size_word, 1'b0, 32'h0, 0, 0);
        add_row(1'b0, 32'h0000_0010, 4'h0, 32'h0, size_word, 1'b0, 32'hc3f1_5a73, 0, 0);
        add_row(1'b0, 32'h0000_0012, 4'h0, 32'h0, size_half, 1'b1, 32'hffff_c3f1, 0, 0);
        add_row(1'b0, 32'h0000_0012, 4'h0, 32'h0, size_half, 1'b0, 32'h0000_c3f1, 0, 0);
        add_row(1'b0, 32'h0000_0011, 4'h0, 32'h0, size_byte, 1'b1, 32'h0000_005a, 0, 0);
        add_row(1'b0, 32'h0000_0013, 4'h0, 32'h0, size_byte, 1'b1, 32'hffff_ffc3, 0, 0);
        add_row(1'b0, 32'h0000_0010, 4'h0, 32'h0, size_byte, 1'b0, 32'h0000_0073, 0, 0);
        add_row(1'b1, 32'h0000_001c, 4'h5, 32'h1122_3344, size_word, 1'b0, 32'h0, 0, 0);
        add_row(1'b0, 32'h0000_001c, 4'h0, 32'h0, size_word, 1'b0, 32'hdc22_ce44, 0, 0);
        // A, B, A, C in set 2 with B left clean
        add_row(1'b0, 32'h0000_0020, 4'h0, 32'h0, size_word, 1'b0, 32'hf8f1_eae3, 1, 0);
        add_row(1'b0, 32'h0000_0420, 4'h0, 32'h0, size_word, 1'b0, 32'hf8f1_eae3, 1, 0);
        add_row(1'b0, 32'h0000_0020, 4'h0, 32'h0, size_word, 1'b0, 32'hf8f1_eae3, 0, 0);
        add_row(1'b0, 32'h0000_0820, 4'h0, 32'h0, size_word, 1'b0, 32'hf8f1_eae3, 1, 0);
        add_row(1'b0, 32'h0000_0020, 4'h0, 32'h0, size_word, 1'b0, 32'hf8f1_eae3, 0, 0);
        add_row(1'b0, 32'h0000_0420, 4'h0, 32'h0, size_word, 1'b0, 32'hf8f1_eae3, 1, 0);
        // same pattern in set 3 with B stored to so its eviction writes back
        add_row(1'b1, 32'h0000_0030, 4'hf, 32'ha5a5_0001, size_word, 1'b0, 32'h0, 1, 0);
        add_row(1'b1, 32'h0000_0434, 4'h3, 32'h0000_beef, size_word, 1'b0, 32'h0, 1, 0);
        add_row(1'b0, 32'h0000_0030, 4'h0, 32'h0, size_word, 1'b0, 32'ha5a5_0001, 0, 0);
        add_row(1'b0, 32'h0000_0830, 4'h0, 32'h0, size_word, 1'b0, 32'h6861_5a53, 1, 1);
        add_row(1'b0, 32'h0000_0434, 4'h0, 32'h0, size_word, 1'b0, 32'h847d_beef, 1, 1);
        add_row(1'b0, 32'h0000_0030, 4'h0, 32'h0, size_word, 1'b0, 32'ha5a5_0001, 1, 0);
        add_row(1'b0, 32'h0000_0436, 4'h0, 32'h0, size_half, 1'b0, 32'h0000_847d, 0, 0);
    endtask

    // one request at a time, entered and left 2 ns after a rising edge
    task automatic run_request(input cpu_req_t r, output word_t got);
        int n;
        cur_addr  = r.addr;
        req       = r;
        req_valid = 1'b1;
        n         = 0;
        do begin
            @(negedge clk);
            assert (resp_valid !== 1'b1) else begin
                $display("response pulse arrived while no request was outstanding");
                other_count++;
            end
            n++;
        end while (busy !== 1'b0 && n < resp_limit);
        assert (busy === 1'b0) else begin
            $display("request at %h was never accepted, busy stayed high", r.addr);
            other_count++;
        end
        req_count++;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        n         = 0;
        do begin
            @(negedge clk);
            n++;
        end while (resp_valid !== 1'b1 && n < resp_limit);
        assert (resp_valid === 1'b1) else begin
            $display("no response within %0d cycles for address %h", resp_limit, r.addr);
            other_count++;
        end
        got = rdata;
        @(posedge clk);
        #2;
    endtask

    task automatic apply_row(input row_t row);
        cpu_req_t q;
        word_t    got;
        int       rd_before;
        int       wr_before;
        q.write   = row.write;
        q.addr    = row.addr;
        q.wstrb   = row.wstrb;
        q.wdata   = row.wdata;
        q.size    = row.size;
        q.sign    = row.sign;
        rd_before = rd_count;
        wr_before = wr_count;
        run_request(q, got);
        if (row.write) begin
            ref_store(row.addr, row.wstrb, row.wdata);
        end else begin
            compare_word("rdata", got, row.exp_data);
            compare_word("rdata (reference)", got, ref_load(row.addr, row.size, row.sign));
        end
        compare_word("mem_req.rd count", word_t'(rd_count - rd_before), word_t'(row.exp_rd));
        compare_word("mem_req.wr count", word_t'(wr_count - wr_before), word_t'(row.exp_wr));
    endtask

    task automatic run_random();
        logic [31:0] r;
        cpu_req_t    q;
        word_t       exp;
        word_t       got;
        rng           = xorshift32(rng);
        r             = rng;
        q.write       = r[7];
        q.size        = load_size_e'(2'(r[13:12] % 3));
        q.sign        = r[14];
        q.addr        = '0;
        q.addr[11:10] = 2'(r[31:16] % 3); // three tags share each set
        q.addr[6:4]   = r[6:4];
        q.addr[3:0]   = r[3:0];
        if (q.size == size_half) begin
            q.addr[0] = 1'b0;
        end else if (q.size == size_word) begin
            q.addr[1:0] = 2'b00;
        end
        rng     = xorshift32(rng);
        q.wdata = rng;
        q.wstrb = '0;
        if (q.write) begin
            case (q.size)
                size_byte: q.wstrb = 4'b0001 << q.addr[1:0];
                size_half: q.wstrb = q.addr[1] ? 4'b1100 : 4'b0011;
                default:   q.wstrb = (r[19:16] == 4'h0) ? 4'hf : r[19:16];
            endcase
        end
        exp = ref_load(q.addr, q.size, q.sign);
        run_request(q, got);
        if (q.write) begin
            ref_store(q.addr, q.wstrb, q.wdata);
        end else begin
            compare_word("rdata", got, exp);
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    endtask

    // memory side monitor
    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            if (resp_valid === 1'b1) begin
                pulse_count++;
            end
            if (mem_req.rd === 1'b1 && !rd_q) begin
                rd_count++;
                assert (mem_req.addr === {cur_addr[31:4], 4'h0}) else begin
                    $display("MISMATCH mem_req.addr: expected %h, got %h",
                             {cur_addr[31:4], 4'h0}, mem_req.addr);
                    mismatch_count++;
                end
            end
            if (mem_req.wr === 1'b1 && !wr_q) begin
                wr_count++;
                // victim shares the set of the request but not its tag
                assert (mem_req.addr[9:0] === {cur_addr[9:4], 4'h0}) else begin
                    $display("MISMATCH mem_req.addr[9:0]: expected %h, got %h",
                             {cur_addr[9:4], 4'h0}, mem_req.addr[9:0]);
                    mismatch_count++;
                end
                assert (mem_req.addr[31:10] !== cur_addr[31:10]) else begin
                    $display("write-back went to the requested line instead of the victim");
                    other_count++;
                end
                assert (mem_req.wdata === ref_line(mem_req.addr)) else begin
                    $display("MISMATCH mem_req.wdata: expected %h, got %h",
                             ref_line(mem_req.addr), mem_req.wdata);
                    mismatch_count++;
                end
            end
            assert (!(mem_req.rd === 1'b1 && mem_req.wr === 1'b1)) else begin
                $display("memory read and write were requested in the same cycle");
                other_count++;
            end
            rd_q = (mem_req.rd === 1'b1);
            wr_q = (mem_req.wr === 1'b1);
        end
    end

    initial begin
        arst_n         = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        rng            = 32'h3741_8583;
        cur_addr       = '0;
        mismatch_count = 0;
        other_count    = 0;
        req_count      = 0;
        pulse_count    = 0;
        rd_count       = 0;
        wr_count       = 0;
        rd_q           = 1'b0;
        wr_q           = 1'b0;
        for (int i = 0; i < ref_bytes; i++) begin
            ref_mem[i] = 8'(i*7 + 3); // same fill as the memory model
        end
        build_table();
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        assert (busy === 1'b0 && resp_valid === 1'b0 && mem_req.rd === 1'b0
                && mem_req.wr === 1'b0) else begin
            $display("busy, resp_valid or a memory strobe was not low after reset");
            other_count++;
        end
        @(posedge clk);
        #2;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
        end
        repeat (num_random) begin
            run_random();
        end
        repeat (5) @(posedge clk); // room for a stray pulse
        assert (pulse_count == req_count) else begin
            $display("%0d response pulses seen for %0d requests", pulse_count, req_count);
            other_count++;
        end
        report_counts();
        if (mismatch_count + other_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = (rows.size() + num_random) * 200;
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        report_counts();
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- dcache.f
design/dcache_pkg.sv
design/dcache_ctrl.sv
design/dcache_ways.sv
design/dcache_plru.sv
design/dcache_word_path.sv
design/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv
